// ==== Makefile ====
VERILATOR ?= verilator
TOP := tb_video_scaler
FILELIST := files.f
BUILD_DIR := obj_dir
LOG := sim.log
VFLAGS := --binary --timing --assert -Wno-fatal --top-module $(TOP) -Mdir $(BUILD_DIR)
LINT_FLAGS := --lint-only -Wall --timing --assert --top-module $(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "TB FAILED" $(LOG); then \
		echo "simulation failed"; exit 1; \
	fi
	@if ! grep -q "TB PASSED" $(LOG); then \
		echo "simulation ended without a result line"; exit 1; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== files.f ====
+incdir+.
scaler_pkg.sv
line_fifo.sv
hscaler.sv
vscaler.sv
video_scaler_top.sv
video_scaler_sva.sv
tb_video_scaler.sv

// ==== hscaler.sv ====
`timescale 1ns/1ps
`default_nettype none

module hscaler (
	input wire clk,
	input wire int_resetn,
	input wire scaler_pkg::reso_t i_ori_width,
	input wire scaler_pkg::reso_t i_scale_width,
	input wire i_valid,
	input wire scaler_pkg::pix_t i_data,
	input wire i_sof,
	input wire i_eol,
	input wire o_ready,
	output logic o_valid,
	output scaler_pkg::pix_t o_data,
	output logic o_sof,
	output logic o_eol,
	output logic i_ready
);
	import scaler_pkg::*;

	// widths of the running frame
	reso_t ori_w_q;
	reso_t scl_w_q;
	reso_t ori_w;
	reso_t scl_w;
	logic cfg_new;

	logic armed;
	// output reg holds a pixel that still has copies to send
	logic pend;
	logic pend_eol;

	// next output column and its product with ori_width
	reso_t o_col;
	reso_t o_col_nx;
	acc_t o_acc;
	// current source column times scale_width
	acc_t s_acc;
	acc_t lim;

	logic use_pix;
	logic more_pix;
	logic out_free;
	logic in_acc;
	logic load_new;
	logic load_rep;
	logic load;
	logic pix_done;
	logic cur_eol;

	////////////////////////////////////////
	// sampling decision
	////////////////////////////////////////

	// a new frame brings its own widths on the sof beat
	assign cfg_new = i_valid && i_sof && !pend;
	assign ori_w = cfg_new ? i_ori_width : ori_w_q;
	assign scl_w = cfg_new ? i_scale_width : scl_w_q;

	assign o_col_nx = reso_t'(o_col + 1'b1);
	assign lim = s_acc + acc_t'(scl_w);
	// column k belongs to source c while k*ori < (c+1)*scale
	assign use_pix = (o_acc < lim) && (o_col < scl_w);
	assign more_pix = ((o_acc + acc_t'(ori_w)) < lim) && (o_col_nx < scl_w);

	assign out_free = !o_valid || o_ready;
	// unused pixels are dropped even when the output is stalled
	assign i_ready = armed && !pend && (out_free || !use_pix);
	assign in_acc = i_valid && i_ready;
	assign load_new = in_acc && use_pix;
	assign load_rep = pend && out_free;
	assign load = load_new || load_rep;

	assign pix_done = (in_acc && !use_pix) || (load && !more_pix);
	assign cur_eol = pend ? pend_eol : i_eol;

	always_ff @(posedge clk) begin
		if (int_resetn == 1'b0) begin
			armed <= 1'b0;
		end else begin
			armed <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (int_resetn == 1'b0) begin
			ori_w_q <= '0;
			scl_w_q <= '0;
		end else if (in_acc && i_sof) begin
			ori_w_q <= i_ori_width;
			scl_w_q <= i_scale_width;
		end
	end

	////////////////////////////////////////
	// column accumulators
	////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (int_resetn == 1'b0) begin
			o_col <= '0;
			o_acc <= '0;
			s_acc <= '0;
			pend <= 1'b0;
			pend_eol <= 1'b0;
		end else begin
			if (pix_done && cur_eol) begin
				// line finished, restart at column 0
				o_col <= '0;
				o_acc <= '0;
				s_acc <= '0;
			end else begin
				if (load) begin
					o_col <= o_col_nx;
					o_acc <= o_acc + acc_t'(ori_w);
				end
				if (pix_done) begin
					s_acc <= lim;
				end
			end
			if (load) begin
				pend <= more_pix;
			end
			if (load_new) begin
				pend_eol <= i_eol;
			end
		end
	end

	////////////////////////////////////////
	// output register
	////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (int_resetn == 1'b0) begin
			o_valid <= 1'b0;
		end else if (load) begin
			o_valid <= 1'b1;
		end else if (o_ready) begin
			o_valid <= 1'b0;
		end
	end

	// source column 0 always maps to output column 0, so sof never drops
	always_ff @(posedge clk) begin
		if (load_new) begin
			o_data <= i_data;
		end
		if (load) begin
			o_sof <= load_new && i_sof;
			o_eol <= (o_col_nx == scl_w);
		end
	end

endmodule

`default_nettype wire

// ==== line_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "scaler_defs.svh"

module line_fifo (
	input wire clk,
	input wire int_resetn,
	input wire i_wr_en,
	input wire scaler_pkg::line_word_t i_wr_data,
	input wire i_rd_en,
	output scaler_pkg::line_word_t o_rd_data,
	output logic o_empty,
	output logic o_full
);
	import scaler_pkg::*;

	localparam int ADDR_W = $clog2(`LINE_PIXELS);
	localparam int CNT_W = ADDR_W + 1;

	line_word_t mem [`LINE_PIXELS];
	logic [ADDR_W-1:0] wr_ptr;
	logic [ADDR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic do_wr;
	logic do_rd;

	// head word is visible whenever not empty
	assign o_rd_data = mem[rd_ptr];
	assign o_empty = (count == '0);
	assign o_full = (count == CNT_W'(`LINE_PIXELS));

	assign do_rd = i_rd_en && !o_empty;
	// a read frees a slot in the same cycle, so a line can recirculate
	assign do_wr = i_wr_en && (!o_full || do_rd);

	always_ff @(posedge clk) begin
		if (do_wr) begin
			mem[wr_ptr] <= i_wr_data;
		end
	end

	always_ff @(posedge clk) begin
		if (int_resetn == 1'b0) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_wr) begin
				if (wr_ptr == ADDR_W'(`LINE_PIXELS - 1)) begin
					wr_ptr <= '0;
				end else begin
					wr_ptr <= wr_ptr + 1'b1;
				end
			end
			if (do_rd) begin
				if (rd_ptr == ADDR_W'(`LINE_PIXELS - 1)) begin
					rd_ptr <= '0;
				end else begin
					rd_ptr <= rd_ptr + 1'b1;
				end
			end
			// occupancy
			case ({do_wr, do_rd})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== scaler_defs.svh ====
`ifndef SCALER_DEFS_SVH
`define SCALER_DEFS_SVH

////////////////////////////////////////
// stream and size widths
////////////////////////////////////////

// bits per grey-scale pixel
`define PIXEL_WIDTH 8

// bits in a width, height or line/column count
`define RESO_WIDTH 10

////////////////////////////////////////
// line buffer
////////////////////////////////////////

// fifo depth, also the widest scaled line
`define LINE_PIXELS 64

// largest original width or height
`define RESO_MAX 64

`endif

// ==== scaler_pkg.sv ====
`default_nettype none

`include "scaler_defs.svh"

package scaler_pkg;

	////////////////////////////////////////
	// stream payload
	////////////////////////////////////////

	// one grey-scale pixel
	typedef logic [`PIXEL_WIDTH-1:0] pix_t;

	// sizes and line/column counts
	typedef logic [`RESO_WIDTH-1:0] reso_t;

	// step accumulator, holds count * size with headroom
	typedef logic [2*`RESO_WIDTH:0] acc_t;

	////////////////////////////////////////
	// line fifo word
	////////////////////////////////////////

	// pixel plus its frame and line flags
	typedef struct packed {
		pix_t pix;
		logic sof;
		logic eol;
	} line_word_t;

endpackage

`default_nettype wire

// ==== tb_video_scaler.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "scaler_defs.svh"

module tb_video_scaler;
	import scaler_pkg::*;

	localparam int CLK_HALF = 50;
	localparam int RESET_CYCLES = 16;
	localparam logic [31:0] LFSR_SEED = 32'h2847;

	logic clk;
	logic int_resetn;
	reso_t ori_width;
	reso_t ori_height;
	reso_t scale_width;
	reso_t scale_height;
	logic s_valid;
	pix_t s_data;
	logic s_sof;
	logic s_eol;
	logic s_ready;
	logic m_valid;
	pix_t m_data;
	logic m_sof;
	logic m_eol;
	logic m_ready;

	logic bp_en;
	logic [31:0] pix_lfsr;
	logic [31:0] rdy_lfsr;
	pix_t src [`RESO_MAX*`RESO_MAX];
	pix_t exp_pix [$];
	logic exp_sof [$];
	logic exp_eol [$];
	pix_t got_pix [$];
	logic got_sof [$];
	logic got_eol [$];
	int err_pix;
	int err_flag;
	int err_count;
	int err_other;
	int cycle_count;
	int timeout_limit;

	video_scaler_top video_scaler_top_inst (
		.clk(clk),
		.int_resetn(int_resetn),
		.i_ori_width(ori_width),
		.i_ori_height(ori_height),
		.i_scale_width(scale_width),
		.i_scale_height(scale_height),
		.i_s_valid(s_valid),
		.i_s_data(s_data),
		.i_s_sof(s_sof),
		.i_s_eol(s_eol),
		.o_s_ready(s_ready),
		.o_m_valid(m_valid),
		.o_m_data(m_data),
		.o_m_sof(m_sof),
		.o_m_eol(m_eol),
		.i_m_ready(m_ready)
	);

	always #CLK_HALF clk = ~clk;

	////////////////////////////////////////
	// random source and back-pressure
	////////////////////////////////////////

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] state);
		logic fb;
		fb = state[31] ^ state[21] ^ state[1] ^ state[0];
		return {state[30:0], fb};
	endfunction

	task automatic next_pixel(output pix_t p);
		p = '0;
		for (int b = 0; b < `PIXEL_WIDTH; b++) begin
			pix_lfsr = lfsr_next(pix_lfsr);
			p = {p[`PIXEL_WIDTH-2:0], pix_lfsr[0]};
		end
	endtask

	always @(negedge clk) begin
		if (bp_en) begin
			rdy_lfsr = lfsr_next(rdy_lfsr);
			m_ready = rdy_lfsr[0];
		end else begin
			m_ready = 1'b1;
		end
	end

	// output capture
	always @(posedge clk) begin
		if (int_resetn && m_valid && m_ready) begin
			got_pix.push_back(m_data);
			got_sof.push_back(m_sof);
			got_eol.push_back(m_eol);
		end
	end

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count >= timeout_limit) begin
			$display("run timed out after %0d cycles waiting for the DUT", cycle_count);
			$display("TB FAILED");
			$finish;
		end
	end

	////////////////////////////////////////
	// compare tasks
	////////////////////////////////////////

	task automatic check_pix(input string name, input pix_t exp_v, input pix_t act_v);
		if (exp_v !== act_v) begin
			err_pix++;
			$display("Error %s pixel: expected %02h, actual %02h", name, exp_v, act_v);
		end
	endtask

	task automatic check_flag(input string name, input string what, input logic exp_v,
		input logic act_v);
		if (exp_v !== act_v) begin
			err_flag++;
			$display("Error %s %s: expected %b, actual %b", name, what, exp_v, act_v);
		end
	endtask

	task automatic check_count(input string name, input reso_t exp_v, input reso_t act_v);
		if (exp_v !== act_v) begin
			err_count++;
			$display("Error %s lines: expected %0d, actual %0d", name, exp_v, act_v);
		end
	endtask

	////////////////////////////////////////
	// frame model and stream driver
	////////////////////////////////////////

	function automatic int frame_beats(input int ow, input int oh, input int sw, input int sh);
		return ow * oh + sw * sh;
	endfunction

	task automatic fill_source(input int ow, input int oh);
		pix_t p;
		for (int i = 0; i < ow * oh; i++) begin
			next_pixel(p);
			src[i] = p;
		end
	endtask

	// nearest neighbour: floor(k*ori/scale) per axis
	task automatic build_expected(input int ow, input int oh, input int sw, input int sh);
		int sx;
		int sy;
		for (int j = 0; j < sh; j++) begin
			sy = (j * oh) / sh;
			for (int k = 0; k < sw; k++) begin
				sx = (k * ow) / sw;
				exp_pix.push_back(src[sy * ow + sx]);
				exp_sof.push_back(j == 0 && k == 0);
				exp_eol.push_back(k == sw - 1);
			end
		end
	endtask

	task automatic send_frame(input int ow, input int oh, input int sw, input int sh);
		for (int y = 0; y < oh; y++) begin
			for (int x = 0; x < ow; x++) begin
				@(negedge clk);
				// new sizes ride along with the sof beat
				if (x == 0 && y == 0) begin
					ori_width = reso_t'(ow);
					ori_height = reso_t'(oh);
					scale_width = reso_t'(sw);
					scale_height = reso_t'(sh);
				end
				s_valid = 1'b1;
				s_data = src[y * ow + x];
				s_sof = (x == 0 && y == 0);
				s_eol = (x == ow - 1);
				@(posedge clk);
				while (!s_ready) begin
					@(posedge clk);
				end
			end
		end
	endtask

	task automatic idle_input();
		@(negedge clk);
		s_valid = 1'b0;
		s_sof = 1'b0;
		s_eol = 1'b0;
	endtask

	task automatic wait_output(input int n);
		while (got_pix.size() < n) begin
			@(negedge clk);
		end
	endtask

	task automatic compare_output(input string name, input int sw, input int sh);
		int lines;
		lines = 0;
		for (int i = 0; i < sw * sh; i++) begin
			if (got_eol[i]) begin
				lines++;
			end
		end
		check_count(name, reso_t'(sh), reso_t'(lines));
		for (int i = 0; i < sw * sh; i++) begin
			check_pix(name, exp_pix.pop_front(), got_pix.pop_front());
			check_flag(name, "sof", exp_sof.pop_front(), got_sof.pop_front());
			check_flag(name, "eol", exp_eol.pop_front(), got_eol.pop_front());
		end
	endtask

	task automatic run_test(input string name, input int ow, input int oh, input int sw,
		input int sh);
		fill_source(ow, oh);
		build_expected(ow, oh, sw, sh);
		send_frame(ow, oh, sw, sh);
		idle_input();
		wait_output(sw * sh);
		compare_output(name, sw, sh);
	endtask

	////////////////////////////////////////
	// directed tests
	////////////////////////////////////////

	initial begin
		clk = 1'b0;
		int_resetn = 1'b0;
		ori_width = '0;
		ori_height = '0;
		scale_width = '0;
		scale_height = '0;
		s_valid = 1'b0;
		s_data = '0;
		s_sof = 1'b0;
		s_eol = 1'b0;
		m_ready = 1'b1;
		bp_en = 1'b0;
		pix_lfsr = LFSR_SEED;
		rdy_lfsr = LFSR_SEED;
		err_pix = 0;
		err_flag = 0;
		err_count = 0;
		err_other = 0;
		cycle_count = 0;
		timeout_limit = 4 * (frame_beats(8, 4, 8, 4) + frame_beats(5, 3, 12, 3)
			+ frame_beats(6, 3, 6, 8) + frame_beats(16, 12, 7, 5)
			+ frame_beats(6, 3, 6, 8) + frame_beats(32, 2, 64, 5)
			+ frame_beats(10, 6, 4, 9) + frame_beats(9, 5, 13, 3)) + 1000;

		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		int_resetn = 1'b1;

		run_test("identity", 8, 4, 8, 4);
		run_test("h_upscale", 5, 3, 12, 3);
		run_test("v_upscale", 6, 3, 6, 8);
		run_test("downscale", 16, 12, 7, 5);

		@(posedge clk);
		bp_en = 1'b1;
		run_test("back_pressure", 6, 3, 6, 8);
		@(posedge clk);
		bp_en = 0;

		// a full-width line fills the line fifo and recirculates while full
		run_test("wide_line", 32, 2, 64, 5);

		// second frame follows with no idle cycle
		fill_source(10, 6);
		build_expected(10, 6, 4, 9);
		send_frame(10, 6, 4, 9);
		fill_source(9, 5);
		build_expected(9, 5, 13, 3);
		send_frame(9, 5, 13, 3);
		idle_input();
		wait_output(4 * 9 + 13 * 3);
		compare_output("two_frames_a", 4, 9);
		compare_output("two_frames_b", 13, 3);

		repeat (20) @(negedge clk);
		if (got_pix.size() != 0) begin
			err_other++;
			$display("%0d output beats came out that no test expected", got_pix.size());
		end

		$display("errors: pixel %0d, flag %0d, line count %0d, other %0d",
			err_pix, err_flag, err_count, err_other);
		if (err_pix + err_flag + err_count + err_other == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== video_scaler_sva.sv ====
`timescale 1ns/1ps
`default_nettype none

module video_scaler_sva (
	input wire clk,
	input wire int_resetn,
	input wire i_m_valid,
	input wire scaler_pkg::pix_t i_m_data,
	input wire i_m_sof,
	input wire i_m_eol,
	input wire i_m_ready,
	input wire i_fifo_wr,
	input wire i_fifo_rd,
	input wire i_fifo_full
);

	// a stalled output beat holds until taken
	assert property (@(posedge clk) disable iff (!int_resetn)
		(i_m_valid && !i_m_ready) |=> (i_m_valid && $stable(i_m_data)
		&& $stable(i_m_sof) && $stable(i_m_eol)))
		else $error("output beat changed while the sink stalled");

	// a full line fifo only takes a word while it also gives one
	assert property (@(posedge clk) disable iff (!int_resetn)
		(i_fifo_wr && i_fifo_full) |-> i_fifo_rd)
		else $error("write to a full line fifo");

	assert property (@(posedge clk) !int_resetn |=> !i_m_valid)
		else $error("output valid high right after reset");

endmodule

bind video_scaler_top video_scaler_sva video_scaler_sva_inst (
	.clk(clk),
	.int_resetn(int_resetn),
	.i_m_valid(o_m_valid),
	.i_m_data(o_m_data),
	.i_m_sof(o_m_sof),
	.i_m_eol(o_m_eol),
	.i_m_ready(i_m_ready),
	.i_fifo_wr(vscaler_inst.fifo_wr),
	.i_fifo_rd(vscaler_inst.fifo_rd),
	.i_fifo_full(vscaler_inst.fifo_full)
);

`default_nettype wire

// ==== video_scaler_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module video_scaler_top (
	input wire clk,
	input wire int_resetn,
	input wire scaler_pkg::reso_t i_ori_width,
	input wire scaler_pkg::reso_t i_ori_height,
	input wire scaler_pkg::reso_t i_scale_width,
	input wire scaler_pkg::reso_t i_scale_height,
	input wire i_s_valid,
	input wire scaler_pkg::pix_t i_s_data,
	input wire i_s_sof,
	input wire i_s_eol,
	output logic o_s_ready,
	output logic o_m_valid,
	output scaler_pkg::pix_t o_m_data,
	output logic o_m_sof,
	output logic o_m_eol,
	input wire i_m_ready
);
	import scaler_pkg::*;

	// link between the two stages
	logic h_valid;
	pix_t h_data;
	logic h_sof;
	logic h_eol;
	logic h_ready;

	////////////////////////////////////////
	// columns first, then lines
	////////////////////////////////////////

	hscaler hscaler_inst (
		.clk(clk),
		.int_resetn(int_resetn),
		.i_ori_width(i_ori_width),
		.i_scale_width(i_scale_width),
		.i_valid(i_s_valid),
		.i_data(i_s_data),
		.i_sof(i_s_sof),
		.i_eol(i_s_eol),
		.o_ready(h_ready),
		.o_valid(h_valid),
		.o_data(h_data),
		.o_sof(h_sof),
		.o_eol(h_eol),
		.i_ready(o_s_ready)
	);

	vscaler vscaler_inst (
		.clk(clk),
		.int_resetn(int_resetn),
		.i_ori_height(i_ori_height),
		.i_scale_height(i_scale_height),
		.i_scale_width(i_scale_width),
		.i_valid(h_valid),
		.i_data(h_data),
		.i_sof(h_sof),
		.i_eol(h_eol),
		.o_ready(i_m_ready),
		.o_valid(o_m_valid),
		.o_data(o_m_data),
		.o_sof(o_m_sof),
		.o_eol(o_m_eol),
		.i_ready(h_ready)
	);

endmodule

`default_nettype wire

// ==== vscaler.sv ====
`timescale 1ns/1ps
`default_nettype none

module vscaler (
	input wire clk,
	input wire int_resetn,
	input wire scaler_pkg::reso_t i_ori_height,
	input wire scaler_pkg::reso_t i_scale_height,
	input wire scaler_pkg::reso_t i_scale_width,
	input wire i_valid,
	input wire scaler_pkg::pix_t i_data,
	input wire i_sof,
	input wire i_eol,
	input wire o_ready,
	output logic o_valid,
	output scaler_pkg::pix_t o_data,
	output logic o_sof,
	output logic o_eol,
	output logic i_ready
);
	import scaler_pkg::*;

	// sizes of the running frame
	reso_t ori_h_q;
	reso_t scl_h_q;
	reso_t scl_w_q;
	reso_t ori_h;
	reso_t scl_h;
	reso_t scl_w;
	logic cfg_new;

	logic armed;
	logic replay;
	// source lines consumed, output lines finished
	reso_t i_line;
	reso_t o_line;
	reso_t rep_col;
	// o_mul = o_line * ori_height, m_mul = i_line * scale_height
	acc_t o_mul;
	acc_t m_mul;
	acc_t lim;

	logic use_line;
	logic more_line;
	logic out_free;
	logic in_acc;
	logic pass_beat;
	logic in_eol_done;
	logic last_in_line;
	logic rep_end;
	logic frame_end;
	logic load;

	line_word_t wr_word;
	line_word_t rd_word;
	logic fifo_wr;
	logic fifo_rd;
	logic fifo_empty;
	logic fifo_full;

	////////////////////////////////////////
	// line decision
	////////////////////////////////////////

	assign cfg_new = i_valid && i_sof && !replay;
	assign ori_h = cfg_new ? i_ori_height : ori_h_q;
	assign scl_h = cfg_new ? i_scale_height : scl_h_q;
	assign scl_w = cfg_new ? i_scale_width : scl_w_q;

	// upper bound of the source line in output-line units,
	// m_mul has already moved on during replay
	assign lim = replay ? m_mul : (m_mul + acc_t'(scl_h));
	assign use_line = (o_mul < lim) && (o_line < scl_h);
	// another copy of this line follows the current one
	assign more_line = ((o_mul + acc_t'(ori_h)) < lim)
		&& (reso_t'(o_line + 1'b1) < scl_h);

	assign out_free = !o_valid || o_ready;
	// pass needs the output, drop takes one beat per cycle
	assign i_ready = armed && !replay
		&& (!use_line || (out_free && !(more_line && fifo_full)));
	assign in_acc = i_valid && i_ready;
	assign pass_beat = in_acc && use_line;
	assign in_eol_done = in_acc && i_eol;
	assign last_in_line = (reso_t'(i_line + 1'b1) == ori_h);

	assign fifo_rd = replay && out_free && !fifo_empty;
	assign rep_end = fifo_rd && (rep_col == reso_t'(scl_w - 1'b1));
	assign load = pass_beat || fifo_rd;
	// store on pass, write back on every copy but the last
	assign fifo_wr = load && more_line;
	assign wr_word = replay ? rd_word : line_word_t'{pix: i_data, sof: i_sof, eol: i_eol};

	// all lines of the frame in and out
	assign frame_end = (in_eol_done && last_in_line && !(pass_beat && more_line))
		|| (rep_end && !more_line && (i_line == ori_h));

	line_fifo line_fifo_inst (
		.clk(clk),
		.int_resetn(int_resetn),
		.i_wr_en(fifo_wr),
		.i_wr_data(wr_word),
		.i_rd_en(fifo_rd),
		.o_rd_data(rd_word),
		.o_empty(fifo_empty),
		.o_full(fifo_full)
	);

	always_ff @(posedge clk) begin
		if (int_resetn == 1'b0) begin
			armed <= 1'b0;
		end else begin
			armed <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (int_resetn == 1'b0) begin
			ori_h_q <= '0;
			scl_h_q <= '0;
			scl_w_q <= '0;
		end else if (in_acc && i_sof) begin
			ori_h_q <= i_ori_height;
			scl_h_q <= i_scale_height;
			scl_w_q <= i_scale_width;
		end
	end

	////////////////////////////////////////
	// line counters and mode
	////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (int_resetn == 1'b0) begin
			replay <= 1'b0;
			i_line <= '0;
			o_line <= '0;
			rep_col <= '0;
			o_mul <= '0;
			m_mul <= '0;
		end else if (frame_end) begin
			// rearm for the next sof
			replay <= 1'b0;
			i_line <= '0;
			o_line <= '0;
			rep_col <= '0;
			o_mul <= '0;
			m_mul <= '0;
		end else begin
			if (in_eol_done) begin
				i_line <= reso_t'(i_line + 1'b1);
				m_mul <= m_mul + acc_t'(scl_h);
				if (pass_beat) begin
					o_line <= reso_t'(o_line + 1'b1);
					o_mul <= o_mul + acc_t'(ori_h);
					replay <= more_line;
				end
			end
			if (fifo_rd) begin
				if (rep_end) begin
					rep_col <= '0;
					o_line <= reso_t'(o_line + 1'b1);
					o_mul <= o_mul + acc_t'(ori_h);
					if (!more_line) begin
						replay <= 1'b0;
					end
				end else begin
					rep_col <= reso_t'(rep_col + 1'b1);
				end
			end
		end
	end

	////////////////////////////////////////
	// output register
	////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (int_resetn == 1'b0) begin
			o_valid <= 1'b0;
		end else if (load) begin
			o_valid <= 1'b1;
		end else if (o_ready) begin
			o_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (pass_beat) begin
			o_data <= i_data;
			o_sof <= i_sof;
			o_eol <= i_eol;
		end else if (fifo_rd) begin
			// copies never start a frame
			o_data <= rd_word.pix;
			o_sof <= 1'b0;
			o_eol <= rd_word.eol;
		end
	end

endmodule

`default_nettype wire
